// ==== barrel_shifter.sv ====
`default_nettype none

module barrel_shifter
  import cpu_pkg::*;
(
  input  word_t      operand,
  input  shift_e     shift_kind,
  input  logic [4:0] shift_amount,
  input  logic       rotate_imm,
  output word_t      result
);

  logic [4:0] amount;
  logic [5:0] rot_back;
  word_t      rotated;

  // Immediate operands rotate by twice the 4-bit field
  assign amount = rotate_imm ? {shift_amount[3:0], 1'b0} : shift_amount;

  // Amount 0 gives a shift of 32 here, which clears the wrapped half
  assign rot_back = 6'd32 - {1'b0, amount};
  assign rotated  = (operand >> amount) | (operand << rot_back);

  always_comb begin
    result = operand;
    if (rotate_imm) begin
      result = rotated;
    end else begin
      case (shift_kind)
        SH_LSL: result = operand << amount;
        SH_LSR: result = operand >> amount;
        SH_ASR: result = $signed(operand) >>> amount;
        SH_ROR: result = rotated;
        default: result = operand;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== cpu_alu.sv ====
`default_nettype none

`include "cpu_config.svh"

module cpu_alu
  import cpu_pkg::*;
(
  input  word_t    a_bus,
  input  word_t    b_bus,
  input  control_t ctrl,
  input  flags_t   flags_in,
  output word_t    result,
  output flags_t   flags_out
);

  word_t              b_shifted;
  word_t              add_x;
  word_t              add_y;
  logic               add_cin;
  logic               arith;
  logic [`CPU_XLEN:0] sum;
  logic               overflow;

  barrel_shifter shifter_inst (
    .operand      (b_bus),
    .shift_kind   (ctrl.shift_kind),
    .shift_amount (ctrl.shift_amount),
    .rotate_imm   (ctrl.rotate_imm),
    .result       (b_shifted)
  );

  // Adder operands, subtraction as x + ~y + 1
  always_comb begin
    add_x   = a_bus;
    add_y   = b_shifted;
    add_cin = 1'b0;
    arith   = 1'b0;
    case (ctrl.alu_op)
      OP_ADD: begin
        arith = 1'b1;
      end
      OP_SUB, OP_CMP: begin
        add_y   = ~b_shifted;
        add_cin = 1'b1;
        arith   = 1'b1;
      end
      OP_RSB: begin
        add_x   = b_shifted;
        add_y   = ~a_bus;
        add_cin = 1'b1;
        arith   = 1'b1;
      end
      default: ;
    endcase
  end

  assign sum      = {1'b0, add_x} + {1'b0, add_y} + {{`CPU_XLEN{1'b0}}, add_cin};
  assign overflow = (add_x[`CPU_XLEN-1] == add_y[`CPU_XLEN-1]) &&
                    (sum[`CPU_XLEN-1] != add_x[`CPU_XLEN-1]);

  always_comb begin
    case (ctrl.alu_op)
      OP_AND:  result = a_bus & b_shifted;
      OP_EOR:  result = a_bus ^ b_shifted;
      OP_ORR:  result = a_bus | b_shifted;
      OP_BIC:  result = a_bus & ~b_shifted;
      OP_MOV:  result = b_shifted;
      OP_SUB, OP_CMP, OP_RSB, OP_ADD: result = sum[`CPU_XLEN-1:0];
      default: result = b_shifted;
    endcase
  end

  // Logical ops leave C and V alone
  assign flags_out.n = result[`CPU_XLEN-1];
  assign flags_out.z = (result == '0);
  assign flags_out.c = arith ? sum[`CPU_XLEN] : flags_in.c;
  assign flags_out.v = arith ? overflow : flags_in.v;

  always_comb begin
    if (!$isunknown(ctrl.alu_op)) begin
      assert (ctrl.alu_op inside {OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_CMP,
                                  OP_ORR, OP_MOV, OP_BIC, OP_PASS_B})
      else $error("cpu_alu: illegal alu_op %h", ctrl.alu_op);
    end
  end

endmodule

`default_nettype wire

// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Word and register file sizes, fixed by the instruction format
`define CPU_XLEN      32
`define CPU_NUM_REGS  16

// Architectural register roles
`define CPU_PC_IDX    15
`define CPU_LR_IDX    14

// First fetch address
`define CPU_RESET_PC  32'h0000_0000

`endif

// ==== cpu_control.sv ====
`default_nettype none

module cpu_control
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  instr_t   ir,
  input  flags_t   flags,
  output control_t ctrl
);

  cpu_state_e state;
  cpu_state_e state_next;
  logic       cond_pass;
  logic       is_dp;
  logic       is_mem;
  logic       is_branch;
  word_t      branch_offset;

  function automatic logic eval_cond(cond_e cond, flags_t f);
    logic pass;
    case (cond)
      COND_EQ: pass = f.z;
      COND_NE: pass = !f.z;
      COND_CS: pass = f.c;
      COND_CC: pass = !f.c;
      COND_MI: pass = f.n;
      COND_PL: pass = !f.n;
      COND_VS: pass = f.v;
      COND_VC: pass = !f.v;
      COND_HI: pass = f.c && !f.z;
      COND_LS: pass = !f.c || f.z;
      COND_GE: pass = (f.n == f.v);
      COND_LT: pass = (f.n != f.v);
      COND_GT: pass = !f.z && (f.n == f.v);
      COND_LE: pass = f.z || (f.n != f.v);
      COND_AL: pass = 1'b1;
      default: pass = 1'b0;
    endcase
    return pass;
  endfunction

  // ======================================================================
  // Decode
  // ======================================================================

  assign cond_pass = eval_cond(ir.dp.cond, flags);
  assign is_dp     = (ir.dp.cls == 2'b00);
  assign is_mem    = (ir.dp.cls == 2'b01);
  assign is_branch = (ir.dp.cls == 2'b10) && ir.dp.imm_flag;

  // PC already points at fetch + 4, the extra 4 makes fetch + 8
  assign branch_offset = {{6{ir.br.offset24[23]}}, ir.br.offset24, 2'b00} + 32'd4;

  // ======================================================================
  // State machine
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RESET_ADDR;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      RESET_ADDR: state_next = FETCH;
      FETCH:      state_next = EXECUTE;
      EXECUTE:    state_next = (is_mem && cond_pass) ? MEMORY : PC_ADDR;
      MEMORY:     state_next = PC_ADDR;
      PC_ADDR:    state_next = FETCH;
      default:    state_next = RESET_ADDR;
    endcase
  end

  // ======================================================================
  // Control word
  // ======================================================================

  always_comb begin
    ctrl            = '0;
    ctrl.alu_op     = OP_PASS_B;
    ctrl.shift_kind = SH_LSL;
    ctrl.b_src      = B_NONE;
    ctrl.writeback  = WB_NONE;
    ctrl.addr_src   = ADDR_HOLD;
    case (state)
      RESET_ADDR: begin
        ctrl.addr_src = ADDR_PC;
      end
      FETCH: begin
        ctrl.read_en  = 1'b1;
        ctrl.latch_ir = 1'b1;
        ctrl.pc_incr  = 1'b1;
      end
      EXECUTE: begin
        // Failed condition leaves the word idle
        if (cond_pass && is_dp) begin
          ctrl.alu_op    = ir.dp.opcode;
          ctrl.set_flags = ir.dp.s_bit || (ir.dp.opcode == OP_CMP);
          ctrl.writeback = (ir.dp.opcode == OP_CMP) ? WB_NONE : WB_RD;
          if (ir.dp.imm_flag) begin
            ctrl.b_src        = B_IMM;
            ctrl.b_imm        = {24'd0, ir.dp.operand2[7:0]};
            ctrl.shift_kind   = SH_ROR;
            ctrl.shift_amount = {1'b0, ir.dp.operand2[11:8]};
            ctrl.rotate_imm   = 1'b1;
          end else begin
            ctrl.b_src        = B_REG_RM;
            ctrl.shift_kind   = shift_e'(ir.dp.operand2[6:5]);
            ctrl.shift_amount = ir.dp.operand2[11:7];
          end
        end else if (cond_pass && is_mem) begin
          ctrl.alu_op   = ir.mem.up_bit ? OP_ADD : OP_SUB;
          ctrl.b_src    = B_IMM;
          ctrl.b_imm    = {20'd0, ir.mem.offset12};
          ctrl.addr_src = ADDR_ALU;
        end else if (cond_pass && is_branch) begin
          ctrl.alu_op    = OP_ADD;
          ctrl.b_src     = B_IMM;
          ctrl.b_imm     = branch_offset;
          ctrl.pc_branch = 1'b1;
          ctrl.writeback = ir.br.link ? WB_LR : WB_NONE;
        end
      end
      MEMORY: begin
        if (ir.mem.load_bit) begin
          ctrl.read_en        = 1'b1;
          ctrl.b_src          = B_READ_DATA;
          ctrl.load_writeback = 1'b1;
        end else begin
          ctrl.write_en = 1'b1;
          ctrl.b_src    = B_REG_RD;
        end
      end
      PC_ADDR: begin
        ctrl.addr_src   = ADDR_PC;
        ctrl.instr_done = 1'b1;
      end
      default: ;
    endcase
  end

  // ======================================================================
  // Checks
  // ======================================================================

  assert property (@(posedge clk) disable iff (reset)
    state inside {RESET_ADDR, FETCH, EXECUTE, MEMORY, PC_ADDR})
  else $error("cpu_control: illegal state %h", state);

  // Completion only closes an executed instruction
  assert property (@(posedge clk) disable iff (reset)
    ctrl.instr_done |-> (state == PC_ADDR) && ($past(state) inside {EXECUTE, MEMORY}))
  else $error("cpu_control: instr_done outside PC_ADDR");

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`default_nettype none

`include "cpu_config.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  output mem_req_t mem_req,
  input  word_t    rdata,
  output logic     instr_done
);

  word_t    regs [`CPU_NUM_REGS];
  flags_t   flags;
  flags_t   alu_flags;
  instr_t   ir;
  word_t    addr_reg;
  word_t    pc;
  word_t    a_bus;
  word_t    b_bus;
  word_t    alu_result;
  control_t ctrl;

  cpu_control control_inst (
    .clk   (clk),
    .reset (reset),
    .ir    (ir),
    .flags (flags),
    .ctrl  (ctrl)
  );

  cpu_alu alu_inst (
    .a_bus     (a_bus),
    .b_bus     (b_bus),
    .ctrl      (ctrl),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  assign pc = regs[`CPU_PC_IDX];

  // ======================================================================
  // Operand buses
  // ======================================================================

  // Branches add their offset to the PC
  assign a_bus = ctrl.pc_branch ? pc : regs[ir.dp.rn];

  always_comb begin
    case (ctrl.b_src)
      B_IMM:       b_bus = ctrl.b_imm;
      B_READ_DATA: b_bus = rdata;
      B_REG_RM:    b_bus = regs[ir.dp.operand2[3:0]];
      B_REG_RD:    b_bus = regs[ir.dp.rd];
      default:     b_bus = '0;
    endcase
  end

  // ======================================================================
  // Instruction register and flags
  // ======================================================================

  always_ff @(posedge clk) begin
    if (ctrl.latch_ir) begin
      ir <= rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (ctrl.set_flags) begin
      flags <= alu_flags;
    end
  end

  // ======================================================================
  // Register writeback
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      regs[`CPU_PC_IDX] <= `CPU_RESET_PC;
    end else begin
      if (ctrl.pc_branch) begin
        regs[`CPU_PC_IDX] <= alu_result;
      end else if (ctrl.pc_incr) begin
        regs[`CPU_PC_IDX] <= pc + 32'd4;
      end

      case (ctrl.writeback)
        WB_RD:   regs[ir.dp.rd] <= alu_result;
        WB_LR:   regs[`CPU_LR_IDX] <= pc;   // return address at fetch + 4
        default: ;
      endcase

      if (ctrl.load_writeback) begin
        regs[ir.dp.rd] <= b_bus;
      end
    end
  end

  // ======================================================================
  // Address register and memory bus
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_reg <= `CPU_RESET_PC;
    end else begin
      case (ctrl.addr_src)
        ADDR_ALU: addr_reg <= alu_result;
        ADDR_PC:  addr_reg <= pc;
        default:  ;
      endcase
    end
  end

  always_comb begin
    mem_req.addr     = addr_reg;
    mem_req.read_en  = ctrl.read_en;
    mem_req.write_en = ctrl.write_en;
    mem_req.wdata    = b_bus;
  end

  assign instr_done = ctrl.instr_done;

  assert property (@(posedge clk) disable iff (reset)
    !(mem_req.read_en && mem_req.write_en))
  else $error("cpu_core: read_en and write_en both high");

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;

  // ======================================================================
  // Encodings
  // ======================================================================

  typedef enum logic [3:0] {
    COND_EQ = 4'b0000,
    COND_NE = 4'b0001,
    COND_CS = 4'b0010,
    COND_CC = 4'b0011,
    COND_MI = 4'b0100,
    COND_PL = 4'b0101,
    COND_VS = 4'b0110,
    COND_VC = 4'b0111,
    COND_HI = 4'b1000,
    COND_LS = 4'b1001,
    COND_GE = 4'b1010,
    COND_LT = 4'b1011,
    COND_GT = 4'b1100,
    COND_LE = 4'b1101,
    COND_AL = 4'b1110,
    COND_NV = 4'b1111
  } cond_e;

  // Data-processing opcodes keep their instruction encoding
  typedef enum logic [3:0] {
    OP_AND    = 4'b0000,
    OP_EOR    = 4'b0001,
    OP_SUB    = 4'b0010,
    OP_RSB    = 4'b0011,
    OP_ADD    = 4'b0100,
    OP_CMP    = 4'b1010,
    OP_ORR    = 4'b1100,
    OP_MOV    = 4'b1101,
    OP_BIC    = 4'b1110,
    OP_PASS_B = 4'b1111   // MVN slot, unused by the subset
  } alu_op_e;

  typedef enum logic [1:0] {
    SH_LSL = 2'b00,
    SH_LSR = 2'b01,
    SH_ASR = 2'b10,
    SH_ROR = 2'b11
  } shift_e;

  typedef enum logic [2:0] {
    RESET_ADDR,
    FETCH,
    EXECUTE,
    MEMORY,
    PC_ADDR
  } cpu_state_e;

  typedef enum logic [2:0] {
    B_NONE,
    B_IMM,
    B_READ_DATA,
    B_REG_RM,
    B_REG_RD
  } b_src_e;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_RD,
    WB_LR
  } wb_sel_e;

  typedef enum logic [1:0] {
    ADDR_HOLD,
    ADDR_ALU,
    ADDR_PC
  } addr_src_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // ======================================================================
  // Instruction register views
  // ======================================================================

  typedef struct packed {
    cond_e       cond;
    logic [1:0]  cls;
    logic        imm_flag;
    alu_op_e     opcode;
    logic        s_bit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dp_fields_t;

  // Single data transfer, P/B/W bits are fixed by the subset
  typedef struct packed {
    logic [7:0]  head;
    logic        up_bit;
    logic [1:0]  byte_wb;
    logic        load_bit;
    logic [7:0]  reg_fields;
    logic [11:0] offset12;
  } mem_fields_t;

  typedef struct packed {
    logic [6:0]  head;
    logic        link;
    logic [23:0] offset24;
  } br_fields_t;

  typedef union packed {
    dp_fields_t  dp;
    mem_fields_t mem;
    br_fields_t  br;
  } instr_t;

  // ======================================================================
  // Control word and memory bus
  // ======================================================================

  typedef struct packed {
    alu_op_e   alu_op;
    shift_e    shift_kind;
    logic [4:0] shift_amount;
    logic      rotate_imm;
    b_src_e    b_src;
    word_t     b_imm;
    wb_sel_e   writeback;
    logic      load_writeback;
    logic      set_flags;
    logic      latch_ir;
    logic      pc_incr;
    logic      pc_branch;
    addr_src_e addr_src;
    logic      read_en;
    logic      write_en;
    logic      instr_done;
  } control_t;

  typedef struct packed {
    word_t addr;
    logic  read_en;
    logic  write_en;
    word_t wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+.
cpu_pkg.sv
barrel_shifter.sv
cpu_alu.sv
cpu_control.sv
cpu_core.sv
tb_clock_gen.sv
tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f files.f \
  -o Vtb_cpu

./obj_dir/Vtb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for three rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  logic     clk;
  logic     reset;
  mem_req_t mem_req;
  word_t    rdata;
  logic     instr_done;

  word_t  mem [1024];
  word_t  m_mem [1024];
  word_t  m_regs [16];
  word_t  m_pc;
  flags_t m_flags;

  word_t fetch_q [$];
  int    cyc_q [$];
  word_t st_addr_q [$];
  word_t st_data_q [$];

  int wi;
  int up_slot;
  int limit;
  int n_instr;
  int since_rel;
  int last_done;
  int done_count;
  int value_errors;
  int timing_errors;
  int protocol_errors;
  logic expect_fetch;
  logic seen_read;
  logic run_done;

  tb_clock_gen clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  cpu_core cpu_core_inst (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .rdata      (rdata),
    .instr_done (instr_done)
  );

  // ======================================================================
  // Memory model with combinational read and a write on the rising edge
  // ======================================================================

  assign rdata = mem[mem_req.addr[11:2]];

  always @(posedge clk) begin
    if (mem_req.write_en) begin
      mem[mem_req.addr[11:2]] <= mem_req.wdata;
    end
  end

  // ======================================================================
  // Instruction encoders
  // ======================================================================

  function automatic word_t enc_dp(logic [3:0] cond, logic [3:0] op, logic s, logic i,
                                   logic [3:0] rn, logic [3:0] rd, logic [11:0] op2);
    return {cond, 2'b00, i, op, s, rn, rd, op2};
  endfunction

  function automatic word_t enc_imm(logic [3:0] cond, logic [3:0] op, logic s,
                                    logic [3:0] rn, logic [3:0] rd,
                                    logic [3:0] rot, logic [7:0] imm);
    return enc_dp(cond, op, s, 1'b1, rn, rd, {rot, imm});
  endfunction

  function automatic word_t enc_reg(logic [3:0] cond, logic [3:0] op, logic s,
                                    logic [3:0] rn, logic [3:0] rd, logic [4:0] amt,
                                    logic [1:0] sh, logic [3:0] rm);
    return enc_dp(cond, op, s, 1'b0, rn, rd, {amt, sh, 1'b0, rm});
  endfunction

  function automatic word_t enc_mem(logic [3:0] cond, logic load, logic up,
                                    logic [3:0] rn, logic [3:0] rd, logic [11:0] off);
    return {cond, 3'b010, 1'b1, up, 2'b00, load, rn, rd, off};
  endfunction

  function automatic word_t enc_br(logic [3:0] cond, logic link, int off);
    return {cond, 3'b101, link, off[23:0]};
  endfunction

  task automatic emit(word_t w);
    mem[wi] = w;
    wi++;
  endtask

  task automatic store_up(logic [3:0] cond, logic [3:0] rd);
    emit(enc_mem(cond, 1'b0, 1'b1, 4'd8, rd, 12'(4 * up_slot)));
    up_slot++;
  endtask

  // Random register shift with a nonzero amount except for LSL
  task automatic emit_rand_reg(logic [3:0] op, logic s, logic [3:0] rn, logic [3:0] rd);
    logic [1:0] sh;
    logic [4:0] amt;
    sh  = 2'($urandom % 4);
    amt = (sh == SH_LSL) ? 5'($urandom % 32) : 5'(1 + $urandom % 31);
    emit(enc_reg(COND_AL, op, s, rn, rd, amt, sh, 4'($urandom % 8)));
  endtask

  // ======================================================================
  // Reference instruction-set model
  // ======================================================================

  function automatic word_t ror32(word_t x, int n);
    int k;
    k = n % 32;
    if (k == 0) return x;
    return (x >> k) | (x << (32 - k));
  endfunction

  function automatic word_t shift_op(word_t x, logic [1:0] sh, logic [4:0] amt);
    case (sh)
      2'd0: return x << amt;
      2'd1: return x >> amt;
      2'd2: return word_t'($signed(x) >>> amt);
      default: return ror32(x, int'(amt));
    endcase
  endfunction

  function automatic logic cond_holds(logic [3:0] c, flags_t f);
    case (c)
      4'h0: return f.z;
      4'h1: return !f.z;
      4'h2: return f.c;
      4'h3: return !f.c;
      4'h4: return f.n;
      4'h5: return !f.n;
      4'h6: return f.v;
      4'h7: return !f.v;
      4'h8: return f.c && !f.z;
      4'h9: return !f.c || f.z;
      4'hA: return f.n == f.v;
      4'hB: return f.n != f.v;
      4'hC: return !f.z && (f.n == f.v);
      4'hD: return f.z || (f.n != f.v);
      4'hE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void model_step(output logic mem_exec, output logic st_valid,
                                     output word_t st_addr, output word_t st_data);
    word_t       ins;
    word_t       a;
    word_t       b;
    word_t       r;
    word_t       addr;
    logic [32:0] wide;
    logic [3:0]  op;
    flags_t      nf;
    ins      = m_mem[m_pc[11:2]];
    mem_exec = 1'b0;
    st_valid = 1'b0;
    st_addr  = '0;
    st_data  = '0;
    nf       = m_flags;
    if (!cond_holds(ins[31:28], m_flags)) begin
      m_pc = m_pc + 4;
      return;
    end
    case (ins[27:26])
      2'b00: begin
        op = ins[24:21];
        a  = m_regs[ins[19:16]];
        if (ins[25]) b = ror32({24'd0, ins[7:0]}, 2 * int'(ins[11:8]));
        else b = shift_op(m_regs[ins[3:0]], ins[6:5], ins[11:7]);
        case (op)
          OP_AND: r = a & b;
          OP_EOR: r = a ^ b;
          OP_ORR: r = a | b;
          OP_BIC: r = a & ~b;
          OP_ADD: begin
            wide = {1'b0, a} + {1'b0, b};
            r    = wide[31:0];
            nf.c = wide[32];
            nf.v = (a[31] == b[31]) && (r[31] != a[31]);
          end
          OP_SUB, OP_CMP: begin
            r    = a - b;
            nf.c = (a >= b);
            nf.v = (a[31] != b[31]) && (r[31] != a[31]);
          end
          OP_RSB: begin
            r    = b - a;
            nf.c = (b >= a);
            nf.v = (a[31] != b[31]) && (r[31] != b[31]);
          end
          default: r = b;
        endcase
        nf.n = r[31];
        nf.z = (r == '0);
        if (ins[20] || op == OP_CMP) m_flags = nf;
        if (op != OP_CMP) m_regs[ins[15:12]] = r;
        m_pc = m_pc + 4;
      end
      2'b01: begin
        mem_exec = 1'b1;
        a    = m_regs[ins[19:16]];
        addr = ins[23] ? a + {20'd0, ins[11:0]} : a - {20'd0, ins[11:0]};
        if (ins[20]) begin
          m_regs[ins[15:12]] = m_mem[addr[11:2]];
        end else begin
          m_mem[addr[11:2]] = m_regs[ins[15:12]];
          st_valid = 1'b1;
          st_addr  = addr;
          st_data  = m_regs[ins[15:12]];
        end
        m_pc = m_pc + 4;
      end
      default: begin
        // Target is fetch + 8 plus the word offset
        if (ins[24]) m_regs[14] = m_pc + 4;
        m_pc = m_pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
      end
    endcase
  endfunction

  function automatic logic is_self_branch(word_t ins);
    return ins[31:28] == COND_AL && ins[27:25] == 3'b101 && ins[23:0] == 24'hFFFFFE;
  endfunction

  // ======================================================================
  // Program image and expected trace
  // ======================================================================

  initial begin
    logic [3:0] ops [8];
    logic       mem_exec;
    logic       st_valid;
    word_t      sa;
    word_t      sd;
    int         n_mem;
    int         n_other;
    int         x;
    void'($urandom(32'h41ec));
    ops = '{OP_ADD, OP_SUB, OP_RSB, OP_AND, OP_EOR, OP_ORR, OP_BIC, OP_MOV};
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (i * 32'h9E37_79B9) ^ {i[9:0], 22'h15A5A5};
    end
    wi = 0;
    up_slot = 0;

    // Data processing with r8 as the 0x800 store base
    emit(enc_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd8, 4'd11, 8'h02));
    for (int r = 0; r < 8; r++) begin
      emit(enc_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'(r), 4'($urandom % 16), 8'($urandom)));
    end
    for (int k = 0; k < 24; k++) begin
      x = $urandom % 8;
      if ($urandom % 2 == 0) begin
        emit(enc_imm(COND_AL, ops[x], 1'($urandom), 4'($urandom % 8), 4'($urandom % 8),
                     4'($urandom % 16), 8'($urandom)));
      end else begin
        emit_rand_reg(ops[x], 1'($urandom), 4'($urandom % 8), 4'($urandom % 8));
      end
    end
    for (int r = 0; r < 8; r++) store_up(COND_AL, 4'(r));

    // Flag setting followed by all sixteen condition codes
    for (int rnd = 0; rnd < 6; rnd++) begin
      case (rnd)
        0: emit(enc_reg(COND_AL, OP_CMP, 1'b1, 4'd0, 4'd0, 5'd0, 2'd0, 4'd0));
        1: emit(enc_imm(COND_AL, OP_CMP, 1'b1, 4'($urandom % 8), 4'd0, 4'd0, 8'($urandom)));
        2: emit_rand_reg(OP_ADD, 1'b1, 4'($urandom % 8), 4'd11);
        3: emit_rand_reg(OP_SUB, 1'b1, 4'($urandom % 8), 4'd11);
        4: emit(enc_imm(COND_AL, OP_RSB, 1'b1, 4'($urandom % 8), 4'd11, 4'd0, 8'($urandom)));
        default: emit_rand_reg(OP_CMP, 1'b1, 4'($urandom % 8), 4'd0);
      endcase
      emit(enc_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd10, 4'd0, 8'd0));
      for (int c = 0; c < 16; c++) begin
        emit(enc_imm(4'(c), OP_ORR, 1'b0, 4'd10, 4'd10, 4'(((32 - (c & ~1)) / 2) % 16),
                     8'(1 << (c % 2))));
      end
      store_up(COND_AL, 4'd10);
      store_up(COND_AL, 4'd11);
    end

    // Round trips through memory below the base
    for (int k = 0; k < 4; k++) begin
      emit(enc_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd12, 4'($urandom % 16), 8'($urandom)));
      emit(enc_mem(COND_AL, 1'b0, 1'b0, 4'd8, 4'd12, 12'(4 * (k + 1))));
      x = (k == 3) ? $urandom % 16 : COND_AL;
      emit(enc_mem(4'(x), 1'b1, 1'b0, 4'd8, 4'd13, 12'(4 * (k + 1))));
      store_up(4'(x), 4'd13);
    end

    // BL into a subroutine that branches back, then skip over the subroutine
    emit(enc_br(COND_AL, 1'b1, 1));
    store_up(COND_AL, 4'd14);
    emit(enc_br(COND_AL, 1'b0, 2));
    emit(enc_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd10, 4'd0, 8'h5A));
    store_up(COND_AL, 4'd10);
    emit(enc_br(COND_AL, 1'b0, -6));
    emit(enc_br(COND_AL, 1'b0, 0));
    store_up(COND_AL, 4'd0);
    for (int k = 0; k < 4; k++) begin
      emit_rand_reg(OP_CMP, 1'b1, 4'($urandom % 8), 4'd0);
      emit(enc_br(4'($urandom % 16), 1'b0, 0));
      store_up(COND_AL, 4'(k + 1));
    end
    emit(enc_br(COND_AL, 1'b0, -2));

    // Run the model ahead of the DUT
    for (int i = 0; i < 1024; i++) m_mem[i] = mem[i];
    for (int i = 0; i < 16; i++) m_regs[i] = '0;
    m_pc    = 32'h0000_0000;
    m_flags = '0;
    n_mem   = 0;
    n_other = 0;
    while (!is_self_branch(m_mem[m_pc[11:2]]) && (n_mem + n_other) < 4000) begin
      fetch_q.push_back(m_pc);
      model_step(mem_exec, st_valid, sa, sd);
      cyc_q.push_back(mem_exec ? 4 : 3);
      if (mem_exec) n_mem++;
      else n_other++;
      if (st_valid) begin
        st_addr_q.push_back(sa);
        st_data_q.push_back(sd);
      end
    end
    n_instr = n_mem + n_other;
    limit   = n_mem * 4 + n_other * 3 + 50;
  end

  // ======================================================================
  // Comparison process
  // ======================================================================

  initial begin
    last_done = 0;
    done_count = 0;
    value_errors = 0;
    timing_errors = 0;
    protocol_errors = 0;
    expect_fetch = 1'b1;
    seen_read = 1'b0;
    run_done = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) since_rel <= 0;
    else since_rel <= since_rel + 1;
  end

  always @(negedge clk) begin
    word_t exp_w;
    int    exp_cyc;
    if (since_rel != 0 && !run_done) begin
      if (mem_req.read_en && mem_req.write_en) begin
        $display("read_en and write_en are high together at cycle %0d", since_rel);
        protocol_errors++;
      end
      if (mem_req.read_en && !seen_read) begin
        seen_read = 1'b1;
        if (since_rel != 1) begin
          $display("CHECK FAILED read_en first cycle: got %h expected %h", since_rel, 1);
          timing_errors++;
        end
      end
      if (mem_req.read_en && expect_fetch) begin
        expect_fetch = 1'b0;
        exp_w = fetch_q.pop_front();
        if (mem_req.addr != exp_w) begin
          $display("CHECK FAILED mem_req.addr (fetch): got %h expected %h",
                   mem_req.addr, exp_w);
          value_errors++;
        end
      end
      if (mem_req.write_en) begin
        if (st_addr_q.size() == 0) begin
          $display("Unexpected store to address %h at cycle %0d", mem_req.addr, since_rel);
          protocol_errors++;
        end else begin
          exp_w = st_addr_q.pop_front();
          if (mem_req.addr != exp_w) begin
            $display("CHECK FAILED mem_req.addr (store): got %h expected %h",
                     mem_req.addr, exp_w);
            value_errors++;
          end
          exp_w = st_data_q.pop_front();
          if (mem_req.wdata != exp_w) begin
            $display("CHECK FAILED mem_req.wdata: got %h expected %h", mem_req.wdata, exp_w);
            value_errors++;
          end
        end
      end
      if (instr_done) begin
        exp_cyc = cyc_q.pop_front();
        if (since_rel - last_done != exp_cyc) begin
          $display("CHECK FAILED instr_done interval: got %h expected %h",
                   since_rel - last_done, exp_cyc);
          timing_errors++;
        end
        last_done = since_rel;
        done_count++;
        expect_fetch = 1'b1;
        if (done_count == n_instr) run_done = 1'b1;
      end
      if (since_rel > limit) begin
        $display("Timeout after %0d cycles with %0d of %0d instructions done",
                 since_rel, done_count, n_instr);
        $display("Errors: value %0d, timing %0d, protocol %0d",
                 value_errors, timing_errors, protocol_errors);
        $display("SIMULATION FAILED");
        $finish;
      end
    end
  end

  initial begin
    wait (run_done);
    if (st_addr_q.size() != 0) begin
      $display("%0d expected stores never happened", st_addr_q.size());
      protocol_errors++;
    end
    $display("Errors: value %0d, timing %0d, protocol %0d",
             value_errors, timing_errors, protocol_errors);
    if (value_errors + timing_errors + protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
